//--- run_sim.sh
#!/usr/bin/env bash
# build the execute stage testbench with Verilator, run it, and grade the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_ooo_execute -o sim_ooo_execute \
  && ./obj_dir/sim_ooo_execute > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "STATUS: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- src/arith_unit.sv
// Integer ALU and the arithmetic completion lane with link and CSR results
`timescale 1ns/10ps

module arith_unit #(
  parameter int CB_INDEX_W = 3
) (
  input  ooo_exec_pkg::word_t      port_a,
  input  ooo_exec_pkg::word_t      port_b,
  input  ooo_exec_pkg::word_t      pc,
  input  ooo_exec_pkg::alu_op_t    alu_op,
  input  logic                     alu_ena,
  input  ooo_exec_pkg::reg_idx_t   rd,
  input  logic [CB_INDEX_W-1:0]    cb_index,
  input  logic                     branch_instr,
  input  logic                     jump_instr,
  input  logic                     csr_wait,
  input  logic                     csr_done,
  input  ooo_exec_pkg::word_t      csr_value,
  result_if.producer               alu_lane
);
  import ooo_exec_pkg::*;

  word_t      alu_result;
  logic [4:0] shamt;

  assign shamt = port_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:  alu_result = port_a + port_b;
      ALU_SUB:  alu_result = port_a - port_b;
      ALU_AND:  alu_result = port_a & port_b;
      ALU_OR:   alu_result = port_a | port_b;
      ALU_XOR:  alu_result = port_a ^ port_b;
      ALU_SLT:  alu_result = {31'd0, $signed(port_a) < $signed(port_b)};
      ALU_SLTU: alu_result = {31'd0, port_a < port_b};
      ALU_SLL:  alu_result = port_a << shamt;
      ALU_SRL:  alu_result = port_a >> shamt;
      ALU_SRA:  alu_result = word_t'($signed(port_a) >>> shamt);
      default:  alu_result = '0;
    endcase
  end

  // link address wins, then the latched csr old value
  always_comb begin
    if (jump_instr) begin
      alu_lane.wdata = pc + 32'd4;
    end else if (csr_done) begin
      alu_lane.wdata = csr_value;
    end else begin
      alu_lane.wdata = alu_result;
    end
  end

  assign alu_lane.index = cb_index;
  assign alu_lane.rd    = rd;
  // csr instruction holds the lane until its value is back
  assign alu_lane.ready = alu_ena & ~csr_wait;
  // branches complete without a register write
  assign alu_lane.wen   = ~branch_instr;

endmodule

//--- src/branch_resolver.sv
// Branch and jump resolution with redirect target and mispredict detection
`timescale 1ns/10ps

module branch_resolver (
  input  logic                          CLK,
  input  logic                          nRST,
  input  ooo_exec_pkg::word_t           pc,
  input  ooo_exec_pkg::word_t           port_a,
  input  ooo_exec_pkg::word_t           port_b,
  input  ooo_exec_pkg::word_t           immediate,
  input  logic                          branch_instr,
  input  ooo_exec_pkg::branch_funct_t   branch_funct,
  input  logic                          prediction,
  input  logic                          jump_instr,
  input  logic                          jalr,
  output logic                          mispredict,
  output logic                          mispredict_ff,
  output ooo_exec_pkg::word_t           redirect_addr
);
  import ooo_exec_pkg::*;

  logic  taken;
  word_t pc4;
  word_t branch_addr;
  word_t resolved_addr;
  word_t jump_addr;

  // operand compare, signed or unsigned by funct3
  always_comb begin
    case (branch_funct)
      BEQ:     taken = (port_a == port_b);
      BNE:     taken = (port_a != port_b);
      BLT:     taken = ($signed(port_a) < $signed(port_b));
      BGE:     taken = ($signed(port_a) >= $signed(port_b));
      BLTU:    taken = (port_a < port_b);
      BGEU:    taken = (port_a >= port_b);
      default: taken = 1'b0;
    endcase
  end

  assign pc4           = pc + 32'd4;
  assign branch_addr   = pc + immediate;
  assign resolved_addr = taken ? branch_addr : pc4;

  // jalr target has bit 0 cleared
  assign jump_addr = jalr ? ((port_a + immediate) & ~32'd1) : (pc + immediate);

  // jumps always redirect, branches only on a wrong guess
  assign mispredict    = jump_instr | (branch_instr & (prediction ^ taken));
  assign redirect_addr = jump_instr ? jump_addr : resolved_addr;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      mispredict_ff <= 1'b0;
    end else begin
      mispredict_ff <= mispredict;
    end
  end

endmodule

//--- src/csr_access.sv
// CSR request pulse generation, old-value capture and completion timing
`timescale 1ns/10ps

module csr_access (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        csr_instr,
  input  ooo_exec_pkg::csr_op_t       csr_op,
  input  ooo_exec_pkg::csr_addr_t     csr_addr,
  input  ooo_exec_pkg::word_t         csr_wdata,
  input  ooo_exec_pkg::word_t         csr_rdata_in,
  output logic                        csr_valid_write,
  output ooo_exec_pkg::csr_op_t       csr_req_op,
  output ooo_exec_pkg::csr_addr_t     csr_req_addr,
  output ooo_exec_pkg::word_t         csr_req_wdata,
  output logic                        csr_wait,
  output logic                        csr_done,
  output ooo_exec_pkg::word_t         csr_value
);
  import ooo_exec_pkg::*;

  logic csr_reg;
  logic csr_pulse;

  // first cycle of the held level
  assign csr_pulse = csr_instr & ~csr_reg;

  assign csr_req_op      = csr_pulse ? csr_op : CSR_NONE;
  assign csr_req_addr    = csr_addr;
  assign csr_req_wdata   = csr_wdata;
  assign csr_valid_write = csr_pulse & (csr_op != CSR_NONE);

  // masked in every csr cycle except the done one
  assign csr_wait = csr_instr & ~csr_done;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      csr_reg  <= 1'b0;
      csr_done <= 1'b0;
    end else begin
      csr_reg  <= csr_instr;
      csr_done <= csr_pulse;
    end
  end

  always_ff @(posedge CLK) begin
    if (csr_pulse) begin
      csr_value <= csr_rdata_in;
    end
  end

endmodule

//--- src/multiply_unit.sv
// Three-stage pipelined RV32M multiplier with destination and index delay line
`timescale 1ns/10ps

module multiply_unit #(
  parameter int CB_INDEX_W = 3
) (
  input  logic                     CLK,
  input  logic                     nRST,
  input  ooo_exec_pkg::word_t      port_a,
  input  ooo_exec_pkg::word_t      port_b,
  input  ooo_exec_pkg::mul_op_t    mul_op,
  input  logic                     mul_ena,
  input  ooo_exec_pkg::reg_idx_t   rd,
  input  logic [CB_INDEX_W-1:0]    cb_index,
  result_if.producer               mul_lane
);
  import ooo_exec_pkg::*;

  logic                  a_signed;
  logic                  b_signed;
  logic [32:0]           a_s1;
  logic [32:0]           b_s1;
  mul_op_t               op_s1;
  logic [63:0]           prod_s2;
  mul_op_t               op_s2;
  word_t                 res_s3;
  logic [MUL_LATENCY-1:0] vld_q;
  reg_idx_t              rd_q  [MUL_LATENCY];
  logic [CB_INDEX_W-1:0] idx_q [MUL_LATENCY];

  // only mulh and mulhsu treat rs1 as signed, only mulh treats rs2 so
  assign a_signed = (mul_op == MULH) | (mul_op == MULHSU);
  assign b_signed = (mul_op == MULH);

  // valid bit per stage
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[MUL_LATENCY-2:0], mul_ena};
    end
  end

  // datapath and tag delay line
  always_ff @(posedge CLK) begin
    a_s1     <= {a_signed & port_a[31], port_a};
    b_s1     <= {b_signed & port_b[31], port_b};
    op_s1    <= mul_op;
    prod_s2  <= {{31{a_s1[32]}}, a_s1} * {{31{b_s1[32]}}, b_s1};
    op_s2    <= op_s1;
    res_s3   <= (op_s2 == MUL) ? prod_s2[31:0] : prod_s2[63:32];
    rd_q[0]  <= rd;
    idx_q[0] <= cb_index;
    for (int i = 1; i < MUL_LATENCY; i++) begin
      rd_q[i]  <= rd_q[i-1];
      idx_q[i] <= idx_q[i-1];
    end
  end

  assign mul_lane.index = idx_q[MUL_LATENCY-1];
  assign mul_lane.rd    = rd_q[MUL_LATENCY-1];
  assign mul_lane.wdata = res_s3;
  assign mul_lane.ready = vld_q[MUL_LATENCY-1];
  assign mul_lane.wen   = vld_q[MUL_LATENCY-1];

endmodule

//--- src/ooo_exec_pkg.sv
// Shared types, operation encodings and constants of the out-of-order execute stage
package ooo_exec_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [11:0] csr_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9
  } alu_op_t;

  // same order as the M extension funct3
  typedef enum logic [1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } mul_op_t;

  // RISC-V funct3 encodings
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_funct_t;

  typedef enum logic [1:0] {
    CSR_NONE  = 2'd0,
    CSR_SWAP  = 2'd1,
    CSR_SET   = 2'd2,
    CSR_CLEAR = 2'd3
  } csr_op_t;

  // issue edge to result, in cycles
  localparam int MUL_LATENCY = 3;

endpackage

//--- src/ooo_execute_top.sv
// Scalar out-of-order execute stage with ALU, branch, CSR and multiply lanes
`timescale 1ns/10ps

module ooo_execute_top #(
  parameter int CB_INDEX_W = 3
) (
  input  logic                          CLK,
  input  logic                          nRST,
  input  ooo_exec_pkg::word_t           pc,
  input  ooo_exec_pkg::word_t           port_a,
  input  ooo_exec_pkg::word_t           port_b,
  input  ooo_exec_pkg::word_t           immediate,
  input  ooo_exec_pkg::alu_op_t         alu_op,
  input  logic                          alu_ena,
  input  ooo_exec_pkg::reg_idx_t        rd,
  input  logic [CB_INDEX_W-1:0]         cb_index,
  input  logic                          branch_instr,
  input  ooo_exec_pkg::branch_funct_t   branch_funct,
  input  logic                          prediction,
  input  logic                          jump_instr,
  input  logic                          jalr,
  input  logic                          csr_instr,
  input  ooo_exec_pkg::csr_op_t         csr_op,
  input  ooo_exec_pkg::csr_addr_t       csr_addr,
  input  ooo_exec_pkg::word_t           csr_wdata,
  input  ooo_exec_pkg::word_t           csr_rdata_in,
  input  logic                          mul_ena,
  input  ooo_exec_pkg::mul_op_t         mul_op,
  output logic                          mispredict,
  output logic                          mispredict_ff,
  output ooo_exec_pkg::word_t           redirect_addr,
  output logic                          csr_valid_write,
  output ooo_exec_pkg::csr_op_t         csr_req_op,
  output ooo_exec_pkg::csr_addr_t       csr_req_addr,
  output ooo_exec_pkg::word_t           csr_req_wdata,
  output logic [CB_INDEX_W-1:0]         alu_index,
  output ooo_exec_pkg::reg_idx_t        alu_rd,
  output ooo_exec_pkg::word_t           alu_wdata,
  output logic                          alu_ready,
  output logic                          alu_wen,
  output logic [CB_INDEX_W-1:0]         mul_index,
  output ooo_exec_pkg::reg_idx_t        mul_rd,
  output ooo_exec_pkg::word_t           mul_wdata,
  output logic                          mul_ready,
  output logic                          mul_wen
);
  import ooo_exec_pkg::*;

  logic  csr_wait;
  logic  csr_done;
  word_t csr_value;

  result_if #(.CB_INDEX_W(CB_INDEX_W)) alu_lane ();
  result_if #(.CB_INDEX_W(CB_INDEX_W)) mul_lane ();

  branch_resolver u_branch (
    .CLK, .nRST, .pc, .port_a, .port_b, .immediate,
    .branch_instr, .branch_funct, .prediction, .jump_instr, .jalr,
    .mispredict, .mispredict_ff, .redirect_addr
  );

  csr_access u_csr (
    .CLK, .nRST, .csr_instr, .csr_op, .csr_addr, .csr_wdata, .csr_rdata_in,
    .csr_valid_write, .csr_req_op, .csr_req_addr, .csr_req_wdata,
    .csr_wait, .csr_done, .csr_value
  );

  arith_unit #(.CB_INDEX_W(CB_INDEX_W)) u_arith (
    .port_a, .port_b, .pc, .alu_op, .alu_ena, .rd, .cb_index,
    .branch_instr, .jump_instr, .csr_wait, .csr_done, .csr_value,
    .alu_lane(alu_lane.producer)
  );

  multiply_unit #(.CB_INDEX_W(CB_INDEX_W)) u_mul (
    .CLK, .nRST, .port_a, .port_b, .mul_op, .mul_ena, .rd, .cb_index,
    .mul_lane(mul_lane.producer)
  );

  // completion buffer lanes out as plain ports
  assign alu_index = alu_lane.index;
  assign alu_rd    = alu_lane.rd;
  assign alu_wdata = alu_lane.wdata;
  assign alu_ready = alu_lane.ready;
  assign alu_wen   = alu_lane.wen;

  assign mul_index = mul_lane.index;
  assign mul_rd    = mul_lane.rd;
  assign mul_wdata = mul_lane.wdata;
  assign mul_ready = mul_lane.ready;
  assign mul_wen   = mul_lane.wen;

endmodule

//--- src/result_if.sv
// Completion-buffer result lane between an execution unit and the top level
`timescale 1ns/10ps

interface result_if #(
  parameter int CB_INDEX_W = 3
);
  import ooo_exec_pkg::*;

  logic [CB_INDEX_W-1:0] index;
  reg_idx_t              rd;
  word_t                 wdata;
  // result delivered in any cycle with ready high
  logic                  ready;
  logic                  wen;

  modport producer (
    output index, rd, wdata, ready, wen
  );

  modport consumer (
    input index, rd, wdata, ready, wen
  );

endinterface

//--- tb.f
src/ooo_exec_pkg.sv
src/result_if.sv
src/branch_resolver.sv
src/arith_unit.sv
src/csr_access.sv
src/multiply_unit.sv
src/ooo_execute_top.sv
verification/tb_clock_gen.sv
verification/ooo_execute_checker.sv
verification/tb_ooo_execute.sv

//--- verification/ooo_execute_checker.sv
// Concurrent checks on mispredict, multiplier and CSR request timing of the execute stage
`timescale 1ns/10ps

module ooo_execute_checker (
  input logic CLK,
  input logic nRST,
  input logic mispredict,
  input logic mispredict_ff,
  input logic mul_ena,
  input logic mul_ready,
  input logic csr_valid_write
);
  import ooo_exec_pkg::*;

  // registered copy of the redirect flag
  mispredict_delay: assert property (@(posedge CLK) disable iff (!nRST)
    mispredict_ff == $past(mispredict))
    else $error("mispredict_ff differs from last cycle's mispredict");

  mul_result_origin: assert property (@(posedge CLK) disable iff (!nRST)
    mul_ready |-> $past(mul_ena, MUL_LATENCY))
    else $error("mul_ready without a multiply issued MUL_LATENCY cycles before");

  // one request per held csr level
  csr_single_pulse: assert property (@(posedge CLK) disable iff (!nRST)
    !(csr_valid_write && $past(csr_valid_write)))
    else $error("csr_valid_write high in two consecutive cycles");

endmodule

bind ooo_execute_top ooo_execute_checker chk0 (
  .CLK, .nRST, .mispredict, .mispredict_ff, .mul_ena, .mul_ready, .csr_valid_write
);

//--- verification/tb_clock_gen.sv
// Testbench clock source with an active-low reset held for the first cycles
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 4
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

  // release just after an edge
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1 nRST = 1'b1;
  end

endmodule

//--- verification/tb_ooo_execute.sv
// Directed testbench for the execute stage covering ALU, branch, jump, multiply and CSR paths
`timescale 1ns/10ps

module tb_ooo_execute;
  import ooo_exec_pkg::*;

  localparam int CB_INDEX_W = 3;
  typedef logic [CB_INDEX_W-1:0] cb_index_t;

  logic          CLK;
  logic          nRST;
  word_t         pc;
  word_t         port_a;
  word_t         port_b;
  word_t         immediate;
  alu_op_t       alu_op;
  logic          alu_ena;
  reg_idx_t      rd;
  cb_index_t     cb_index;
  logic          branch_instr;
  branch_funct_t branch_funct;
  logic          prediction;
  logic          jump_instr;
  logic          jalr;
  logic          csr_instr;
  csr_op_t       csr_op;
  csr_addr_t     csr_addr;
  word_t         csr_wdata;
  word_t         csr_rdata_in;
  logic          mul_ena;
  mul_op_t       mul_op;
  logic          mispredict;
  logic          mispredict_ff;
  word_t         redirect_addr;
  logic          csr_valid_write;
  csr_op_t       csr_req_op;
  csr_addr_t     csr_req_addr;
  word_t         csr_req_wdata;
  cb_index_t     alu_index;
  reg_idx_t      alu_rd;
  word_t         alu_wdata;
  logic          alu_ready;
  logic          alu_wen;
  cb_index_t     mul_index;
  reg_idx_t      mul_rd;
  word_t         mul_wdata;
  logic          mul_ready;
  logic          mul_wen;

  int seed;
  int errors;
  int checks;
  int cycle;

  tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(4)) clk0 (.CLK, .nRST);

  ooo_execute_top #(.CB_INDEX_W(CB_INDEX_W)) dut0 (.*);

  always @(posedge CLK) begin
    cycle <= cycle + 1;
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%02h expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_index(input string name, input cb_index_t got, input cb_index_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_csr_op(input string name, input csr_op_t got, input csr_op_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_csr_addr(input string name, input csr_addr_t got, input csr_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%03h expected 0x%03h", name, got, exp);
    end
  endtask

  function automatic logic signed_less(input word_t a, input word_t b);
    return (a[31] != b[31]) ? a[31] : (a < b);
  endfunction

  // reference results from the RV32I and RV32M rules
  function automatic word_t alu_expect(input alu_op_t op, input word_t a, input word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLT:  return {31'd0, signed_less(a, b)};
      ALU_SLTU: return {31'd0, a < b};
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
      default:  return 32'd0;
    endcase
  endfunction

  function automatic logic branch_expect(input branch_funct_t fn, input word_t a,
                                         input word_t b);
    case (fn)
      BEQ:     return a == b;
      BNE:     return a != b;
      BLT:     return signed_less(a, b);
      BGE:     return !signed_less(a, b);
      BLTU:    return a < b;
      BGEU:    return !(a < b);
      default: return 1'b0;
    endcase
  endfunction

  function automatic word_t mul_expect(input mul_op_t op, input word_t a, input word_t b);
    logic [63:0] ua;
    logic [63:0] ub;
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] p;
    ua = {32'd0, a};
    ub = {32'd0, b};
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    case (op)
      MULH:    p = sa * sb;
      MULHSU:  p = sa * ub;
      default: p = ua * ub;
    endcase
    return (op == MUL) ? p[31:0] : p[63:32];
  endfunction

  task automatic clear_inputs();
    pc           = 32'd0;
    port_a       = 32'd0;
    port_b       = 32'd0;
    immediate    = 32'd0;
    alu_op       = ALU_ADD;
    alu_ena      = 1'b0;
    rd           = 5'd0;
    cb_index     = '0;
    branch_instr = 1'b0;
    branch_funct = BEQ;
    prediction   = 1'b0;
    jump_instr   = 1'b0;
    jalr         = 1'b0;
    csr_instr    = 1'b0;
    csr_op       = CSR_NONE;
    csr_addr     = 12'd0;
    csr_wdata    = 32'd0;
    csr_rdata_in = 32'd0;
    mul_ena      = 1'b0;
    mul_op       = MUL;
  endtask

  // inputs change shortly after the rising edge
  task automatic step();
    @(posedge CLK);
    #1;
  endtask

  task automatic report_test(input string name, input int start);
    $display("test %s finished with %0d errors", name, errors - start);
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (nRST !== 1'b1 && n < 20) begin
      @(posedge CLK);
      n++;
    end
    if (nRST !== 1'b1) begin
      errors++;
      $display("reset was never released");
    end
  endtask

  task automatic test_alu();
    alu_op_t op;
    word_t   a;
    word_t   b;
    int      start;
    start = errors;
    for (int i = 0; i < 20; i++) begin
      op = alu_op_t'(i % 10);
      a  = $random(seed);
      b  = $random(seed);
      step();
      clear_inputs();
      port_a   = a;
      port_b   = b;
      alu_op   = op;
      alu_ena  = 1'b1;
      rd       = reg_idx_t'(i);
      cb_index = cb_index_t'(i);
      @(negedge CLK);
      check_word("alu_wdata", alu_wdata, alu_expect(op, a, b));
      check_bit("alu_ready", alu_ready, 1'b1);
      check_bit("alu_wen", alu_wen, 1'b1);
      check_reg("alu_rd", alu_rd, reg_idx_t'(i));
      check_index("alu_index", alu_index, cb_index_t'(i));
    end
    report_test("alu", start);
  endtask

  task automatic test_branch();
    branch_funct_t fns[6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
    word_t         a;
    word_t         b;
    word_t         pa;
    word_t         pb;
    word_t         target;
    logic          want;
    logic          exp_mis;
    logic          prev_mis;
    int            start;
    start    = errors;
    prev_mis = 1'b0;
    foreach (fns[f]) begin
      for (int k = 0; k < 4; k++) begin
        want = k[1];
        a    = $random(seed);
        b    = $random(seed);
        if (a == b) begin
          b = a + 32'd1;
        end
        // operand order that gives the wanted outcome
        pa = a;
        pb = b;
        if (branch_expect(fns[f], a, b) != want) begin
          if (branch_expect(fns[f], b, a) == want) begin
            pa = b;
            pb = a;
          end else begin
            pb = a;
          end
        end
        step();
        clear_inputs();
        pc           = $random(seed) & 32'hffff_fffc;
        immediate    = $random(seed) & 32'hffff_fffe;
        port_a       = pa;
        port_b       = pb;
        branch_funct = fns[f];
        branch_instr = 1'b1;
        prediction   = k[0];
        alu_ena      = 1'b1;
        exp_mis      = want ^ k[0];
        target       = want ? pc + immediate : pc + 32'd4;
        @(negedge CLK);
        check_bit("mispredict", mispredict, exp_mis);
        check_word("redirect_addr", redirect_addr, target);
        check_bit("alu_wen", alu_wen, 1'b0);
        check_bit("mispredict_ff", mispredict_ff, prev_mis);
        prev_mis = exp_mis;
      end
    end
    step();
    clear_inputs();
    @(negedge CLK);
    check_bit("mispredict_ff", mispredict_ff, prev_mis);
    report_test("branch", start);
  endtask

  task automatic test_jump();
    word_t target;
    int    start;
    start = errors;
    for (int i = 0; i < 6; i++) begin
      step();
      clear_inputs();
      pc         = $random(seed) & 32'hffff_fffc;
      port_a     = $random(seed);
      immediate  = $random(seed);
      jump_instr = 1'b1;
      jalr       = i[0];
      alu_ena    = 1'b1;
      rd         = 5'd1;
      target     = jalr ? (port_a + immediate) & 32'hffff_fffe : pc + immediate;
      @(negedge CLK);
      check_bit("mispredict", mispredict, 1'b1);
      check_word("redirect_addr", redirect_addr, target);
      check_word("alu_wdata", alu_wdata, pc + 32'd4);
      check_bit("alu_ready", alu_ready, 1'b1);
    end
    report_test("jump", start);
  endtask

  task automatic wait_mul_ready(output logic ok);
    int n;
    n = 0;
    @(negedge CLK);
    while (!mul_ready && n < 20) begin
      n++;
      @(negedge CLK);
    end
    ok = mul_ready;
  endtask

  task automatic test_mul();
    localparam int N = 8;
    word_t   ma[N];
    word_t   mb[N];
    mul_op_t mo[N];
    int      issued[N];
    logic    ok;
    int      start;
    start = errors;
    ok    = 1'b1;
    for (int i = 0; i < N; i++) begin
      ma[i] = $random(seed);
      mb[i] = $random(seed);
      mo[i] = mul_op_t'(i % 4);
    end
    fork
      begin
        for (int i = 0; i < N; i++) begin
          step();
          clear_inputs();
          port_a    = ma[i];
          port_b    = mb[i];
          mul_op    = mo[i];
          mul_ena   = 1'b1;
          rd        = reg_idx_t'(i + 8);
          cb_index  = cb_index_t'(i);
          issued[i] = cycle;
        end
        step();
        clear_inputs();
      end
      begin
        for (int i = 0; i < N && ok; i++) begin
          wait_mul_ready(ok);
          if (!ok) begin
            errors++;
            $display("multiply %0d never produced a result", i);
          end else begin
            checks++;
            if (cycle != issued[i] + MUL_LATENCY) begin
              errors++;
              $display("multiply %0d arrived in cycle %0d instead of %0d",
                       i, cycle, issued[i] + MUL_LATENCY);
            end
            check_word("mul_wdata", mul_wdata, mul_expect(mo[i], ma[i], mb[i]));
            check_reg("mul_rd", mul_rd, reg_idx_t'(i + 8));
            check_index("mul_index", mul_index, cb_index_t'(i));
            check_bit("mul_wen", mul_wen, 1'b1);
          end
        end
      end
    join
    report_test("multiply", start);
  endtask

  task automatic test_csr();
    word_t     old_value;
    word_t     wdata;
    csr_addr_t addr;
    int        start;
    start     = errors;
    old_value = $random(seed);
    wdata     = $random(seed);
    addr      = csr_addr_t'($random(seed));
    for (int c = 0; c < 4; c++) begin
      step();
      clear_inputs();
      csr_instr    = 1'b1;
      csr_op       = CSR_SET;
      csr_addr     = addr;
      csr_wdata    = wdata;
      alu_ena      = 1'b1;
      rd           = 5'd7;
      cb_index     = cb_index_t'(5);
      // read data only valid in the request cycle
      csr_rdata_in = (c == 0) ? old_value : $random(seed);
      @(negedge CLK);
      check_bit("csr_valid_write", csr_valid_write, c == 0);
      check_bit("alu_ready", alu_ready, c == 1);
      if (c == 0) begin
        check_csr_op("csr_req_op", csr_req_op, CSR_SET);
        check_csr_addr("csr_req_addr", csr_req_addr, addr);
        check_word("csr_req_wdata", csr_req_wdata, wdata);
      end else if (c == 1) begin
        check_word("alu_wdata", alu_wdata, old_value);
        check_reg("alu_rd", alu_rd, 5'd7);
        check_index("alu_index", alu_index, cb_index_t'(5));
      end
    end
    step();
    clear_inputs();
    report_test("csr", start);
  endtask

  initial begin
    seed   = 32'h681c;
    errors = 0;
    checks = 0;
    clear_inputs();
    wait_reset();
    if (errors == 0) begin
      test_alu();
      test_branch();
      test_jump();
      test_mul();
      test_csr();
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
